// ==== source/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

  // Lane opcodes. The 32-bit forms work on the low half of each operand.
  typedef enum logic [3:0] {
    OP_ADD64 = 4'd0,
    OP_ADD32 = 4'd1,
    OP_SUB64 = 4'd2,
    OP_SUB32 = 4'd3,
    OP_AND   = 4'd4,
    OP_OR    = 4'd5,
    OP_XOR   = 4'd6,
    OP_SHL64 = 4'd7,
    OP_SHL32 = 4'd8,
    OP_SHR64 = 4'd9,
    OP_SHR32 = 4'd10,
    OP_SAR64 = 4'd11,
    OP_SAR32 = 4'd12
  } alu_op_e;

  typedef enum logic [2:0] {
    FN_ADD = 3'd0,
    FN_SUB = 3'd1,
    FN_AND = 3'd2,
    FN_OR  = 3'd3,
    FN_XOR = 3'd4
  } arith_fn_e;

  // Where an operand comes from at issue time.
  typedef enum logic [1:0] {
    SRC_REG      = 2'd0,
    SRC_BUS_NOW  = 2'd1,
    SRC_BUS_PREV = 2'd2
  } fwd_src_e;

  localparam int FLAG_W = 4;

  localparam int FLAG_ZERO  = 0;
  localparam int FLAG_SIGN  = 1;
  localparam int FLAG_CARRY = 2;
  localparam int FLAG_OVF   = 3;

endpackage

`default_nettype wire

// ==== source/op_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module op_decode import exec_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      flush,
  input  logic      issue_valid,
  input  alu_op_e   issue_op,
  output logic      arith_en,
  output arith_fn_e arith_fn,
  output logic      shift_en,
  output logic      shift_left,
  output logic      shift_arith,
  output logic      word32
);

  logic      issue_q;
  alu_op_e   op_q;

  logic      is_arith;
  logic      is_shift;
  arith_fn_e fn_c;
  logic      left_c;
  logic      arith_c;
  logic      w32_c;

  // Issue sample stage.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      issue_q <= 1'b0;
    end else begin
      issue_q <= issue_valid & ~flush;
    end
    op_q <= issue_op;
  end

  always_comb begin
    is_arith = 1'b0;
    is_shift = 1'b0;
    fn_c     = FN_ADD;
    left_c   = 1'b0;
    arith_c  = 1'b0;
    w32_c    = 1'b0;
    case (op_q)
      OP_ADD64: is_arith = 1'b1;
      OP_ADD32: begin
        is_arith = 1'b1;
        w32_c    = 1'b1;
      end
      OP_SUB64: begin
        is_arith = 1'b1;
        fn_c     = FN_SUB;
      end
      OP_SUB32: begin
        is_arith = 1'b1;
        fn_c     = FN_SUB;
        w32_c    = 1'b1;
      end
      OP_AND: begin
        is_arith = 1'b1;
        fn_c     = FN_AND;
      end
      OP_OR: begin
        is_arith = 1'b1;
        fn_c     = FN_OR;
      end
      OP_XOR: begin
        is_arith = 1'b1;
        fn_c     = FN_XOR;
      end
      OP_SHL64, OP_SHL32: begin
        is_shift = 1'b1;
        left_c   = 1'b1;
        w32_c    = (op_q == OP_SHL32);
      end
      OP_SHR64, OP_SHR32: begin
        is_shift = 1'b1;
        w32_c    = (op_q == OP_SHR32);
      end
      OP_SAR64, OP_SAR32: begin
        is_shift = 1'b1;
        arith_c  = 1'b1;
        w32_c    = (op_q == OP_SAR32);
      end
      // Unused encodings enable neither unit.
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      arith_en <= 1'b0;
      shift_en <= 1'b0;
    end else begin
      arith_en <= issue_q & is_arith & ~flush;
      shift_en <= issue_q & is_shift & ~flush;
    end
    arith_fn    <= fn_c;
    shift_left  <= left_c;
    shift_arith <= arith_c;
    word32      <= w32_c;
  end

endmodule

`default_nettype wire

// ==== source/operand_forward.sv ====
`timescale 1ns/1ns
`default_nettype none

module operand_forward import exec_pkg::*; #(
  parameter int DATA_W = 64,
  parameter int N_SRC  = 4
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [DATA_W-1:0]              reg_value,
  input  fwd_src_e                       src,
  input  logic [$clog2(N_SRC)-1:0]       bus_idx,
  input  logic [N_SRC-1:0][DATA_W-1:0]   bus,
  output logic [DATA_W-1:0]              operand
);

  logic [N_SRC-1:0][DATA_W-1:0] bus_prev;
  logic [DATA_W-1:0]            pick;
  logic [DATA_W-1:0]            pick_q;

  // Every bus as it stood at the previous edge.
  always_ff @(posedge clk) begin
    bus_prev <= bus;
  end

  always_comb begin
    case (src)
      SRC_BUS_NOW:  pick = bus[bus_idx];
      SRC_BUS_PREV: pick = bus_prev[bus_idx];
      SRC_REG:      pick = reg_value;
      default:      pick = reg_value;
    endcase
  end

  // The second stage lines the operand up with the decoded controls.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pick_q  <= '0;
      operand <= '0;
    end else begin
      pick_q  <= pick;
      operand <= pick_q;
    end
  end

endmodule

`default_nettype wire

// ==== source/alu_arith.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_arith import exec_pkg::*; #(
  parameter int DATA_W = 64
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              flush,
  input  logic              en,
  input  arith_fn_e         fn,
  input  logic              word32,
  input  logic [DATA_W-1:0] a,
  input  logic [DATA_W-1:0] b,
  output logic              valid,
  output logic [DATA_W-1:0] result,
  output logic [FLAG_W-1:0] flags
);

  localparam int HALF = DATA_W / 2;

  logic              sub;
  logic [DATA_W-1:0] b_eff;
  logic [DATA_W:0]   sum_full;
  logic [HALF:0]     sum_half;
  logic [DATA_W-1:0] res_c;
  logic [FLAG_W-1:0] flags_c;
  logic              is_sum;
  logic              top_a;
  logic              top_b;
  logic              top_s;

  assign sub   = (fn == FN_SUB);
  assign b_eff = sub ? ~b : b;

  // Subtraction is a + ~b + 1, so carry is the plain carry out.
  assign sum_full = {1'b0, a} + {1'b0, b_eff} + {{DATA_W{1'b0}}, sub};
  assign sum_half = {1'b0, a[HALF-1:0]} + {1'b0, b_eff[HALF-1:0]} + {{HALF{1'b0}}, sub};

  assign is_sum = (fn == FN_ADD) || (fn == FN_SUB);

  always_comb begin
    case (fn)
      FN_AND:  res_c = a & b;
      FN_OR:   res_c = a | b;
      FN_XOR:  res_c = a ^ b;
      default: res_c = sum_full[DATA_W-1:0];
    endcase
    if (word32) begin
      res_c[DATA_W-1:HALF] = '0;
      if (is_sum) begin
        res_c[HALF-1:0] = sum_half[HALF-1:0];
      end
    end
  end

  // Sign bits of the active width for the overflow test.
  assign top_a = word32 ? a[HALF-1] : a[DATA_W-1];
  assign top_b = word32 ? b_eff[HALF-1] : b_eff[DATA_W-1];
  assign top_s = word32 ? res_c[HALF-1] : res_c[DATA_W-1];

  always_comb begin
    flags_c             = '0;
    flags_c[FLAG_ZERO]  = ~|res_c;
    flags_c[FLAG_SIGN]  = top_s;
    if (is_sum) begin
      flags_c[FLAG_CARRY] = word32 ? sum_half[HALF] : sum_full[DATA_W];
      flags_c[FLAG_OVF]   = (top_a == top_b) && (top_s != top_a);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid <= 1'b0;
    end else begin
      valid <= en & ~flush;
    end
    result <= res_c;
    flags  <= flags_c;
  end

endmodule

`default_nettype wire

// ==== source/alu_shift.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_shift import exec_pkg::*; #(
  parameter int DATA_W = 64
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              flush,
  input  logic              en,
  input  logic              shift_left,
  input  logic              shift_arith,
  input  logic              word32,
  input  logic [DATA_W-1:0] a,
  input  logic [DATA_W-1:0] b,
  output logic              valid,
  output logic [DATA_W-1:0] result,
  output logic [FLAG_W-1:0] flags
);

  localparam int HALF = DATA_W / 2;
  localparam int SH_W = $clog2(DATA_W);

  logic [SH_W-1:0]   amt_full;
  logic [SH_W-2:0]   amt_half;
  logic [DATA_W-1:0] full_res;
  logic [HALF-1:0]   half_res;
  logic [DATA_W-1:0] res_c;
  logic [FLAG_W-1:0] flags_c;

  assign amt_full = b[SH_W-1:0];
  assign amt_half = b[SH_W-2:0];

  always_comb begin
    if (shift_left) begin
      full_res = a << amt_full;
      half_res = a[HALF-1:0] << amt_half;
    end else if (shift_arith) begin
      full_res = $signed(a) >>> amt_full;
      half_res = $signed(a[HALF-1:0]) >>> amt_half;
    end else begin
      full_res = a >> amt_full;
      half_res = a[HALF-1:0] >> amt_half;
    end
  end

  assign res_c = word32 ? {{HALF{1'b0}}, half_res} : full_res;

  always_comb begin
    flags_c            = '0;
    flags_c[FLAG_ZERO] = ~|res_c;
    flags_c[FLAG_SIGN] = word32 ? res_c[HALF-1] : res_c[DATA_W-1];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid <= 1'b0;
    end else begin
      valid <= en & ~flush;
    end
    result <= res_c;
    flags  <= flags_c;
  end

endmodule

`default_nettype wire

// ==== source/result_select.sv ====
`timescale 1ns/1ns
`default_nettype none

module result_select import exec_pkg::*; #(
  parameter int DATA_W = 64
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              flush,
  input  logic              arith_valid,
  input  logic [DATA_W-1:0] arith_result,
  input  logic [FLAG_W-1:0] arith_flags,
  input  logic              shift_valid,
  input  logic [DATA_W-1:0] shift_result,
  input  logic [FLAG_W-1:0] shift_flags,
  output logic [DATA_W-1:0] result,
  output logic              result_valid,
  output logic [FLAG_W-1:0] result_flags
);

  // Decode enables at most one unit per issue, so the order here is arbitrary.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
      result       <= '0;
      result_flags <= '0;
    end else begin
      result_valid <= (arith_valid | shift_valid) & ~flush;
      if (!flush) begin
        if (arith_valid) begin
          result       <= arith_result;
          result_flags <= arith_flags;
        end else if (shift_valid) begin
          result       <= shift_result;
          result_flags <= shift_flags;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/exec_cluster.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_cluster import exec_pkg::*; #(
  parameter int DATA_W = 64,
  parameter int N_EXT  = 3
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          issue_valid,
  input  alu_op_e                       issue_op,
  input  logic [DATA_W-1:0]             a_value,
  input  logic [DATA_W-1:0]             b_value,
  input  fwd_src_e                      a_src,
  input  fwd_src_e                      b_src,
  input  logic [$clog2(N_EXT+1)-1:0]    a_bus,
  input  logic [$clog2(N_EXT+1)-1:0]    b_bus,
  input  logic [N_EXT-1:0][DATA_W-1:0]  ext_bus,
  input  logic                          except,
  output logic [DATA_W-1:0]             result,
  output logic                          result_valid,
  output logic [FLAG_W-1:0]             result_flags
);

  localparam int N_SRC = N_EXT + 1;

  logic [N_SRC-1:0][DATA_W-1:0] fwd_bus;

  logic              arith_en;
  arith_fn_e         arith_fn;
  logic              shift_en;
  logic              shift_left;
  logic              shift_arith;
  logic              word32;

  logic [DATA_W-1:0] opnd_a;
  logic [DATA_W-1:0] opnd_b;

  logic              arith_valid;
  logic [DATA_W-1:0] arith_result;
  logic [FLAG_W-1:0] arith_flags;
  logic              shift_valid;
  logic [DATA_W-1:0] shift_result;
  logic [FLAG_W-1:0] shift_flags;

  // Bus 0 is this lane's own result.
  assign fwd_bus = {ext_bus, result};

  op_decode op_decode_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (except),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .arith_en    (arith_en),
    .arith_fn    (arith_fn),
    .shift_en    (shift_en),
    .shift_left  (shift_left),
    .shift_arith (shift_arith),
    .word32      (word32)
  );

  operand_forward #(.DATA_W(DATA_W), .N_SRC(N_SRC)) fwd_a_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .reg_value (a_value),
    .src       (a_src),
    .bus_idx   (a_bus),
    .bus       (fwd_bus),
    .operand   (opnd_a)
  );

  operand_forward #(.DATA_W(DATA_W), .N_SRC(N_SRC)) fwd_b_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .reg_value (b_value),
    .src       (b_src),
    .bus_idx   (b_bus),
    .bus       (fwd_bus),
    .operand   (opnd_b)
  );

  alu_arith #(.DATA_W(DATA_W)) alu_arith_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .flush  (except),
    .en     (arith_en),
    .fn     (arith_fn),
    .word32 (word32),
    .a      (opnd_a),
    .b      (opnd_b),
    .valid  (arith_valid),
    .result (arith_result),
    .flags  (arith_flags)
  );

  alu_shift #(.DATA_W(DATA_W)) alu_shift_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (except),
    .en          (shift_en),
    .shift_left  (shift_left),
    .shift_arith (shift_arith),
    .word32      (word32),
    .a           (opnd_a),
    .b           (opnd_b),
    .valid       (shift_valid),
    .result      (shift_result),
    .flags       (shift_flags)
  );

  result_select #(.DATA_W(DATA_W)) result_select_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush        (except),
    .arith_valid  (arith_valid),
    .arith_result (arith_result),
    .arith_flags  (arith_flags),
    .shift_valid  (shift_valid),
    .shift_result (shift_result),
    .shift_flags  (shift_flags),
    .result       (result),
    .result_valid (result_valid),
    .result_flags (result_flags)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_exec_cluster.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_exec_cluster import exec_pkg::*; ();

  localparam int DATA_W = 64;
  localparam int N_EXT  = 3;
  localparam int RESET_CYCLES = 5;
  // The tests take about 650 cycles, so this limit leaves a wide margin.
  localparam int TIMEOUT_CYCLES = 2000;

  logic                         clk;
  logic                         rst_n;
  logic                         issue_valid;
  alu_op_e                      issue_op;
  logic [DATA_W-1:0]            a_value;
  logic [DATA_W-1:0]            b_value;
  fwd_src_e                     a_src;
  fwd_src_e                     b_src;
  logic [1:0]                   a_bus;
  logic [1:0]                   b_bus;
  logic [N_EXT-1:0][DATA_W-1:0] ext_bus;
  logic                         except;
  logic [DATA_W-1:0]            result;
  logic                         result_valid;
  logic [FLAG_W-1:0]            result_flags;

  logic [31:0] lfsr_state;
  int          cycle_count = 0;

  exec_cluster #(.DATA_W(DATA_W), .N_EXT(N_EXT)) exec_cluster_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .issue_valid  (issue_valid),
    .issue_op     (issue_op),
    .a_value      (a_value),
    .b_value      (b_value),
    .a_src        (a_src),
    .b_src        (b_src),
    .a_bus        (a_bus),
    .b_bus        (b_bus),
    .ext_bus      (ext_bus),
    .except       (except),
    .result       (result),
    .result_valid (result_valid),
    .result_flags (result_flags)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
      $display("Something failed");
      $fatal(1, "Simulation stopped by the cycle limit");
    end
  end

  // Fibonacci LFSR with taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [63:0] rand_bits(input int nbits);
    logic [63:0] v;
    int          i;
    v = '0;
    for (i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Reference model. Returns the flags above the 64-bit result.
  function automatic logic [67:0] expected_of(input alu_op_e op, input logic [63:0] a,
                                              input logic [63:0] b);
    logic [63:0] r;
    logic [3:0]  f;
    logic [31:0] lo;
    logic        sub;
    logic        w32;
    logic        fill;
    logic [64:0] s64;
    logic [32:0] s32;
    int          w;
    int          amt;
    int          i;
    r = '0;
    f = '0;
    w32 = (op == OP_ADD32) || (op == OP_SUB32) || (op == OP_SHL32) ||
          (op == OP_SHR32) || (op == OP_SAR32);
    w = w32 ? 32 : 64;
    sub = (op == OP_SUB64) || (op == OP_SUB32);
    case (op)
      OP_ADD64, OP_SUB64: begin
        // Carry of a subtraction means no borrow.
        if (sub) begin
          s64 = {a[63], a} - {b[63], b};
          r = a - b;
          f[FLAG_CARRY] = (a >= b);
        end else begin
          s64 = {a[63], a} + {b[63], b};
          r = a + b;
          f[FLAG_CARRY] = (r < a);
        end
        f[FLAG_OVF] = s64[64] ^ s64[63];
      end
      OP_ADD32, OP_SUB32: begin
        if (sub) begin
          s32 = {a[31], a[31:0]} - {b[31], b[31:0]};
          lo = a[31:0] - b[31:0];
          f[FLAG_CARRY] = (a[31:0] >= b[31:0]);
        end else begin
          s32 = {a[31], a[31:0]} + {b[31], b[31:0]};
          lo = a[31:0] + b[31:0];
          f[FLAG_CARRY] = (lo < a[31:0]);
        end
        r = {32'd0, lo};
        f[FLAG_OVF] = s32[32] ^ s32[31];
      end
      OP_AND: r = a & b;
      OP_OR:  r = a | b;
      OP_XOR: r = a ^ b;
      default: begin
        amt = w32 ? {27'd0, b[4:0]} : {26'd0, b[5:0]};
        fill = (op == OP_SAR64) ? a[63] : ((op == OP_SAR32) ? a[31] : 1'b0);
        for (i = 0; i < w; i++) begin
          if (op == OP_SHL64 || op == OP_SHL32) begin
            if (i >= amt) r[i] = a[i - amt];
          end else if (i + amt < w) begin
            r[i] = a[i + amt];
          end else begin
            r[i] = fill;
          end
        end
      end
    endcase
    f[FLAG_ZERO] = (r == 64'd0);
    f[FLAG_SIGN] = r[w - 1];
    return {f, r};
  endfunction

  task automatic check_value(input string test, input string item,
                             input logic [63:0] expected, input logic [63:0] actual);
    if (actual !== expected) begin
      $display("** Error in %s, %s: expected %h, actual %h", test, item, expected, actual);
      $display("Something failed");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic drive_issue(input alu_op_e op, input logic [63:0] a, input logic [63:0] b);
    issue_valid = 1'b1;
    issue_op    = op;
    a_value     = a;
    b_value     = b;
    a_src       = SRC_REG;
    b_src       = SRC_REG;
    a_bus       = 2'd0;
    b_bus       = 2'd0;
  endtask

  task automatic drive_idle();
    issue_valid = 1'b0;
    a_src       = SRC_REG;
    b_src       = SRC_REG;
    a_bus       = 2'd0;
    b_bus       = 2'd0;
  endtask

  task automatic check_output(input string test, input logic [67:0] exp);
    check_value(test, "valid", 64'd1, 64'(result_valid));
    check_value(test, "result", exp[63:0], result);
    check_value(test, "flags", {60'd0, exp[67:64]}, 64'(result_flags));
  endtask

  // Called with an issue driven. Returns in the cycle where its result is valid.
  task automatic collect_result(input string test, input logic [67:0] exp);
    int i;
    for (i = 0; i < 3; i++) begin
      next_cycle();
      drive_idle();
      check_value(test, "valid before latency", 64'd0, 64'(result_valid));
    end
    next_cycle();
    drive_idle();
    check_output(test, exp);
  endtask

  task automatic reset_sequence();
    int i;
    rst_n = 1'b0;
    for (i = 0; i < RESET_CYCLES; i++) begin
      next_cycle();
      check_value("reset", "valid in reset", 64'd0, 64'(result_valid));
    end
    rst_n = 1'b1;
    for (i = 0; i < 5; i++) begin
      next_cycle();
      check_value("reset", "valid after reset", 64'd0, 64'(result_valid));
      check_value("reset", "result after reset", 64'd0, result);
      check_value("reset", "flags after reset", 64'd0, 64'(result_flags));
    end
  endtask

  task automatic arith_ops();
    alu_op_e     ops[7];
    logic [63:0] ea[9];
    logic [63:0] eb[9];
    logic [63:0] a;
    logic [63:0] b;
    int          i;
    int          j;
    ops = '{OP_ADD64, OP_ADD32, OP_SUB64, OP_SUB32, OP_AND, OP_OR, OP_XOR};
    ea = '{64'hffff_ffff_ffff_ffff, 64'h8000_0000_0000_0000, 64'd0,
           64'h7fff_ffff_ffff_ffff, 64'd0, 64'h0000_0000_ffff_ffff,
           64'h0000_0000_7fff_ffff, 64'h0000_0000_8000_0000, 64'hffff_ffff_ffff_ffff};
    eb = '{64'd1, 64'h8000_0000_0000_0000, 64'd0, 64'd1, 64'd1, 64'd1, 64'd1,
           64'h0000_0000_8000_0000, 64'hffff_ffff_ffff_ffff};
    for (i = 0; i < 7; i++) begin
      for (j = 0; j < 12; j++) begin
        if (j < 9) begin
          a = ea[j];
          b = eb[j];
        end else begin
          a = rand_bits(64);
          b = rand_bits(64);
        end
        drive_issue(ops[i], a, b);
        collect_result($sformatf("%s case %0d", ops[i].name(), j), expected_of(ops[i], a, b));
      end
    end
  endtask

  task automatic shift_ops();
    alu_op_e     ops[6];
    logic [5:0]  amts[4];
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] r;
    int          i;
    int          j;
    int          k;
    ops = '{OP_SHL64, OP_SHL32, OP_SHR64, OP_SHR32, OP_SAR64, OP_SAR32};
    amts = '{6'd0, 6'd31, 6'd32, 6'd63};
    for (i = 0; i < 6; i++) begin
      for (j = 0; j < 4; j++) begin
        for (k = 0; k < 2; k++) begin
          a = rand_bits(64);
          // Second pass sets both sign bits so the arithmetic fill shows.
          if (k == 1) a = a | 64'h8000_0000_8000_0000;
          r = rand_bits(58);
          b = {r[57:0], amts[j]};
          drive_issue(ops[i], a, b);
          collect_result($sformatf("%s amount %0d", ops[i].name(), amts[j]),
                         expected_of(ops[i], a, b));
        end
      end
    end
  endtask

  task automatic forwarding_paths();
    logic [63:0] x;
    logic [63:0] p;
    logic [63:0] q;
    logic [63:0] b;
    logic [67:0] ex;
    ext_bus[1] = rand_bits(64);
    next_cycle();
    x = rand_bits(64);
    b = rand_bits(64);
    ext_bus[1] = x;
    drive_issue(OP_ADD64, ~x, b);
    a_src = SRC_BUS_NOW;
    a_bus = 2'd2;
    collect_result("bus 2 current", expected_of(OP_ADD64, x, b));

    p = rand_bits(64);
    q = rand_bits(64);
    ext_bus[0] = p;
    next_cycle();
    ext_bus[0] = q;
    drive_issue(OP_SUB64, 64'd0, 64'd0);
    a_src = SRC_BUS_PREV;
    a_bus = 2'd1;
    b_src = SRC_BUS_NOW;
    b_bus = 2'd1;
    collect_result("bus 1 previous", expected_of(OP_SUB64, p, q));

    p = rand_bits(64);
    q = rand_bits(64);
    ext_bus[2] = p;
    next_cycle();
    ext_bus[2] = q;
    drive_issue(OP_SUB32, 64'd0, 64'd0);
    a_src = SRC_BUS_NOW;
    a_bus = 2'd3;
    b_src = SRC_BUS_PREV;
    b_bus = 2'd3;
    collect_result("bus 3 previous", expected_of(OP_SUB32, q, p));

    x = rand_bits(64);
    b = rand_bits(64);
    ex = expected_of(OP_ADD64, x, b);
    drive_issue(OP_ADD64, x, b);
    collect_result("own result source", ex);
    q = rand_bits(64);
    drive_issue(OP_XOR, 64'd0, q);
    a_src = SRC_BUS_NOW;
    a_bus = 2'd0;
    collect_result("bus 0 forward", expected_of(OP_XOR, ex[63:0], q));
  endtask

  task automatic back_to_back();
    logic [67:0] exp_q[$];
    logic [67:0] exp;
    logic [63:0] r;
    logic [63:0] a;
    logic [63:0] b;
    alu_op_e     op;
    int          c;
    for (c = 0; c < 44; c++) begin
      if (c < 40) begin
        r = rand_bits(4);
        op = alu_op_e'(r[3:0] % 4'd13);
        a = rand_bits(64);
        b = rand_bits(64);
        drive_issue(op, a, b);
        exp_q.push_back(expected_of(op, a, b));
      end else begin
        drive_idle();
      end
      next_cycle();
      if (c >= 3 && c < 43) begin
        exp = exp_q.pop_front();
        check_output($sformatf("stream item %0d", c - 3), exp);
      end else begin
        check_value("stream", "valid outside stream", 64'd0, 64'(result_valid));
      end
    end
  endtask

  // The except edge is the one that samples item 6, so items 3 to 6 are lost.
  task automatic flush_stream();
    logic [67:0] exp_arr[10];
    logic [63:0] r;
    logic [63:0] a;
    logic [63:0] b;
    alu_op_e     op;
    int          c;
    int          j;
    for (c = 0; c < 14; c++) begin
      if (c < 10) begin
        r = rand_bits(4);
        op = alu_op_e'(r[3:0] % 4'd13);
        a = rand_bits(64);
        b = rand_bits(64);
        drive_issue(op, a, b);
        exp_arr[c] = expected_of(op, a, b);
      end else begin
        drive_idle();
      end
      except = (c == 6);
      next_cycle();
      j = c - 3;
      if (j >= 0 && j < 10 && (j < 3 || j > 6)) begin
        check_output($sformatf("flush item %0d", j), exp_arr[j]);
      end else begin
        check_value($sformatf("flush slot %0d", j), "valid", 64'd0, 64'(result_valid));
        if (j >= 3 && j <= 6) begin
          check_value($sformatf("flush slot %0d", j), "held result", exp_arr[2][63:0], result);
          check_value($sformatf("flush slot %0d", j), "held flags",
                      {60'd0, exp_arr[2][67:64]}, 64'(result_flags));
        end
      end
    end
    except = 1'b0;
  endtask

  initial begin
    rst_n       = 1'b0;
    issue_valid = 1'b0;
    issue_op    = OP_ADD64;
    a_value     = '0;
    b_value     = '0;
    a_src       = SRC_REG;
    b_src       = SRC_REG;
    a_bus       = 2'd0;
    b_bus       = 2'd0;
    ext_bus     = '0;
    except      = 1'b0;
    lfsr_state  = 32'd18;

    reset_sequence();
    arith_ops();
    shift_ops();
    forwarding_paths();
    back_to_back();
    flush_stream();
    next_cycle();
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== exec_cluster.f ====
source/exec_pkg.sv
source/op_decode.sv
source/operand_forward.sv
source/alu_arith.sv
source/alu_shift.sv
source/result_select.sv
source/exec_cluster.sv
testbench/tb_exec_cluster.sv

// ==== Makefile ====
# Verilator build and run for the execution lane testbench.

VERILATOR ?= verilator
TOP       ?= tb_exec_cluster
FILELIST  ?= exec_cluster.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
FAIL_MSG  ?= Something failed
PASS_MSG  ?= Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
